// ==== Makefile ====
# Verilator flow for the bus interface testbench
# every variable can be overridden on the command line, e.g. make sim SEED=7

VERILATOR ?= verilator
FILE_LIST ?= list.f
TOP       ?= lx_bus_interface_tb
DUT       ?= lx_bus_interface
SEED      ?= 49
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

RTL_FILES := $(shell grep '^design/' $(FILE_LIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(DUT) $(RTL_FILES)

sim:
	$(VERILATOR) --binary --timing --timescale 1ns/1ps --top-module $(TOP) \
	  -GSEED=$(SEED) -Mdir $(OBJ_DIR) -o sim_$(TOP) -f $(FILE_LIST)
	./$(OBJ_DIR)/sim_$(TOP) | tee $(LOG)
	grep -q 'All tests passed!' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/bus_driver.sv ====
module bus_driver
  import lx_bus_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  send_beat,
  input  logic                  respond,
  input  logic                  clear_bus,
  input  msg_t                  resp_msg,
  input  logic [ADDR_WIDTH-1:0] resp_address,
  input  beat_t                 beat_in,
  output msg_t                  bus_msg_out,
  output logic [ADDR_WIDTH-1:0] bus_address_out,
  output beat_t                 bus_data_out
);

  // all bus outputs come straight from flops
  always_ff @(posedge clock) begin
    if (reset || clear_bus) begin
      bus_msg_out     <= NO_REQ;
      bus_address_out <= '0;
      bus_data_out    <= '0;
    end else begin
      // message and address stay put while the beats go out
      if (respond) begin
        bus_msg_out     <= resp_msg;
        bus_address_out <= resp_address;
      end
      if (send_beat) begin
        bus_data_out <= beat_in;
      end
    end
  end

endmodule

// ==== design/cache_driver.sv ====
module cache_driver
  import lx_bus_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  cache_request,
  input  logic                  cache_write,
  input  logic                  cache_release,
  input  msg_t                  req_msg,
  input  logic [ADDR_WIDTH-1:0] req_address,
  input  line_t                 line_in,
  output msg_t                  cache_msg_out,
  output logic [ADDR_WIDTH-1:0] cache_address_out,
  output line_t                 cache_data_out
);

  logic [ADDR_WIDTH-1:0] line_address;

  // the cache only ever sees whole lines
  assign line_address = {req_address[ADDR_WIDTH-1:LINE_OFFSET_BITS],
                         {LINE_OFFSET_BITS{1'b0}}};

  always_ff @(posedge clock) begin
    if (reset || cache_release) begin
      cache_msg_out     <= NO_REQ;
      cache_address_out <= '0;
      cache_data_out    <= '0;
    end else if (cache_request || cache_write) begin
      cache_msg_out     <= req_msg;
      cache_address_out <= line_address;
      // reads carry no data
      if (cache_write) begin
        cache_data_out <= line_in;
      end else begin
        cache_data_out <= '0;
      end
    end
  end

endmodule

// ==== design/line_buffer.sv ====
module line_buffer
  import lx_bus_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        store_line,
  input  logic        store_beat,
  input  beat_index_t beat_index,
  input  line_t       line_in,
  input  beat_t       beat_in,
  output line_t       line_out,
  output beat_t       beat_out
);

  line_t line_q;

  // whole line comes from the cache and single beats from the bus
  always_ff @(posedge clock) begin
    if (reset) begin
      line_q <= '0;
    end else if (store_line) begin
      for (int w = 0; w < CACHE_WORDS; w++) begin
        line_q.words[w] <= line_in.words[w];
      end
    end else if (store_beat) begin
      line_q.beats[beat_index] <= beat_in;
    end
  end

  assign line_out = line_q;

  // bypass the incoming line so beat 0 can leave on the same edge it is stored
  always_comb begin
    if (store_line) begin
      beat_out = line_in.beats[beat_index];
    end else begin
      beat_out = line_q.beats[beat_index];
    end
  end

endmodule

// ==== design/lx_bus_control.sv ====
module lx_bus_control
  import lx_bus_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  req_ready,
  input  msg_t                  bus_msg_in,
  input  logic [ADDR_WIDTH-1:0] bus_address_in,
  input  msg_t                  cache_msg_in,
  output logic [ADDR_WIDTH-1:0] req_address,
  output msg_t                  req_msg,
  output beat_index_t           beat_index,
  output logic                  store_line,
  output logic                  store_beat,
  output logic                  send_beat,
  output logic                  respond,
  output logic                  clear_bus,
  output logic                  cache_request,
  output logic                  cache_write,
  output logic                  cache_release
);

  state_t      state;
  beat_index_t beat_count;
  logic        read_request;
  logic        write_request;
  logic        accept;
  logic        read_done;
  logic        write_done;
  logic        bus_idle;
  logic        read_flow;
  logic        last_beat;

  // message decode
  assign read_request  = (bus_msg_in == R_REQ) || (bus_msg_in == RFO_BCAST);
  assign write_request = (bus_msg_in == WB_REQ);
  assign accept        = (state == IDLE) && req_ready && (read_request || write_request);
  assign read_done     = (cache_msg_in == MEM_RESP) || (cache_msg_in == MEM_RESP_S);
  assign write_done    = (cache_msg_in == MEM_RESP);
  assign bus_idle      = (bus_msg_in == NO_REQ);
  assign read_flow     = (req_msg == R_REQ) || (req_msg == RFO_BCAST);
  assign last_beat     = (beat_count == beat_index_t'(BEATS - 1));
  assign beat_index    = beat_count;

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= IDLE;
      beat_count <= '0;
      req_msg    <= NO_REQ;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            req_msg    <= bus_msg_in;
            beat_count <= '0;
            state      <= read_request ? READ_LINE : RECEIVE;
          end
        end
        READ_LINE: begin
          // beat 0 leaves together with the response
          if (read_done) begin
            beat_count <= beat_count + 1'b1;
            state      <= SEND_BEATS;
          end
        end
        SEND_BEATS: begin
          beat_count <= beat_count + 1'b1;
          if (last_beat) begin
            state <= WAIT_CLEAR;
          end
        end
        RECEIVE: begin
          beat_count <= beat_count + 1'b1;
          if (last_beat) begin
            state <= WRITE_LINE;
          end
        end
        WRITE_LINE: begin
          if (write_done) begin
            state <= WAIT_CLEAR;
          end
        end
        WAIT_CLEAR: begin
          // requester must drop its message before the next request
          if (bus_idle) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      req_address <= bus_address_in;
    end
  end

  always_comb begin
    store_line    = 1'b0;
    store_beat    = 1'b0;
    send_beat     = 1'b0;
    respond       = 1'b0;
    clear_bus     = 1'b0;
    cache_request = 1'b0;
    cache_write   = 1'b0;
    cache_release = 1'b0;
    case (state)
      READ_LINE: begin
        cache_request = !read_done;
        store_line    = read_done;
        cache_release = read_done;
        respond       = read_done;
        send_beat     = read_done;
      end
      SEND_BEATS: send_beat = 1'b1;
      RECEIVE:    store_beat = 1'b1;
      WRITE_LINE: begin
        cache_write   = !write_done;
        cache_release = write_done;
        respond       = write_done;
      end
      // read data is gone after the last beat while a write-back ack waits for the bus
      WAIT_CLEAR: clear_bus = read_flow || bus_idle;
      default: begin
      end
    endcase
  end

endmodule

// ==== design/lx_bus_interface.sv ====
module lx_bus_interface
  import lx_bus_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  req_ready,
  input  msg_t                  bus_msg_in,
  input  logic [ADDR_WIDTH-1:0] bus_address_in,
  input  beat_t                 bus_data_in,
  output msg_t                  bus_msg_out,
  output logic [ADDR_WIDTH-1:0] bus_address_out,
  output beat_t                 bus_data_out,
  input  msg_t                  cache_msg_in,
  input  line_t                 cache_data_in,
  output msg_t                  cache_msg_out,
  output logic [ADDR_WIDTH-1:0] cache_address_out,
  output line_t                 cache_data_out
);

  logic [ADDR_WIDTH-1:0] req_address;
  msg_t                  req_msg;
  beat_index_t           beat_index;
  logic                  store_line;
  logic                  store_beat;
  logic                  send_beat;
  logic                  respond;
  logic                  clear_bus;
  logic                  cache_request;
  logic                  cache_write;
  logic                  cache_release;
  line_t                 buffered_line;
  beat_t                 selected_beat;

  lx_bus_control i_lx_bus_control (
    .clock          (clock),
    .reset          (reset),
    .req_ready      (req_ready),
    .bus_msg_in     (bus_msg_in),
    .bus_address_in (bus_address_in),
    .cache_msg_in   (cache_msg_in),
    .req_address    (req_address),
    .req_msg        (req_msg),
    .beat_index     (beat_index),
    .store_line     (store_line),
    .store_beat     (store_beat),
    .send_beat      (send_beat),
    .respond        (respond),
    .clear_bus      (clear_bus),
    .cache_request  (cache_request),
    .cache_write    (cache_write),
    .cache_release  (cache_release)
  );

  line_buffer i_line_buffer (
    .clock      (clock),
    .reset      (reset),
    .store_line (store_line),
    .store_beat (store_beat),
    .beat_index (beat_index),
    .line_in    (cache_data_in),
    .beat_in    (bus_data_in),
    .line_out   (buffered_line),
    .beat_out   (selected_beat)
  );

  // the cache response code is passed to the bus unchanged
  bus_driver i_bus_driver (
    .clock           (clock),
    .reset           (reset),
    .send_beat       (send_beat),
    .respond         (respond),
    .clear_bus       (clear_bus),
    .resp_msg        (cache_msg_in),
    .resp_address    (req_address),
    .beat_in         (selected_beat),
    .bus_msg_out     (bus_msg_out),
    .bus_address_out (bus_address_out),
    .bus_data_out    (bus_data_out)
  );

  cache_driver i_cache_driver (
    .clock             (clock),
    .reset             (reset),
    .cache_request     (cache_request),
    .cache_write       (cache_write),
    .cache_release     (cache_release),
    .req_msg           (req_msg),
    .req_address       (req_address),
    .line_in           (buffered_line),
    .cache_msg_out     (cache_msg_out),
    .cache_address_out (cache_address_out),
    .cache_data_out    (cache_data_out)
  );

endmodule

// ==== design/lx_bus_pkg.sv ====
package lx_bus_pkg;

  // datapath geometry
  localparam int DATA_WIDTH = 32;
  localparam int ADDR_WIDTH = 32;
  localparam int MSG_WIDTH = 4;
  localparam int CACHE_WORDS = 4;
  localparam int BUS_WORDS = 2;
  localparam int BEATS = CACHE_WORDS / BUS_WORDS;
  // word-offset bits cleared for a line-aligned address
  localparam int LINE_OFFSET_BITS = 2;

  // bus message codes as used on the shared bus
  typedef enum logic [MSG_WIDTH-1:0] {
    NO_REQ     = 4'd0,
    R_REQ      = 4'd1,
    WB_REQ     = 4'd2,
    RFO_BCAST  = 4'd6,
    MEM_RESP   = 4'd10,
    MEM_RESP_S = 4'd11,
    MEM_C_RESP = 4'd12
  } msg_t;

  typedef logic [DATA_WIDTH-1:0] word_t;
  typedef word_t [BUS_WORDS-1:0] beat_t;

  // one cache line seen as cache words or as bus beats
  // beat 0 holds words 0 and 1
  typedef union packed {
    word_t [CACHE_WORDS-1:0] words;
    beat_t [BEATS-1:0] beats;
  } line_t;

  typedef logic beat_index_t;

  typedef enum logic [2:0] {
    IDLE,
    READ_LINE,
    SEND_BEATS,
    RECEIVE,
    WRITE_LINE,
    WAIT_CLEAR
  } state_t;

endpackage

// ==== list.f ====
design/lx_bus_pkg.sv
design/line_buffer.sv
design/bus_driver.sv
design/cache_driver.sv
design/lx_bus_control.sv
design/lx_bus_interface.sv
test/cache_model.sv
test/lx_bus_interface_tb.sv

// ==== test/cache_model.sv ====
module cache_model
  import lx_bus_pkg::*;
#(
  parameter int SEED = 49
) (
  input  logic                  clock,
  input  logic                  reset,
  input  msg_t                  cache_msg_out,
  input  logic [ADDR_WIDTH-1:0] cache_address_out,
  input  line_t                 cache_data_out,
  output msg_t                  cache_msg_in,
  output line_t                 cache_data_in
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int LINES = 8;

  line_t      lines [LINES];
  integer     seed = SEED;
  logic       busy;
  logic       answering;
  int         countdown;
  logic [2:0] index;

  // line number from the word address
  assign index = cache_address_out[LINE_OFFSET_BITS+2:LINE_OFFSET_BITS];

  function automatic word_t fill_word(input int line, input int word);
    return word_t'(32'h5a00_0000 + line * 256 + word);
  endfunction

  always @(posedge clock) begin : answer
    int   draw;
    logic fire;
    fire = 1'b0;
    if (reset) begin
      cache_msg_in  <= NO_REQ;
      cache_data_in <= '0;
      busy          <= 1'b0;
      answering     <= 1'b0;
      countdown     <= 0;
      for (int i = 0; i < LINES; i++) begin
        for (int w = 0; w < CACHE_WORDS; w++) begin
          lines[i].words[w] <= fill_word(i, w);
        end
      end
    end else if (answering) begin
      // the DUT takes the response on this edge
      cache_msg_in  <= NO_REQ;
      cache_data_in <= '0;
      answering     <= 1'b0;
    end else if (busy) begin
      if (countdown == 0) begin
        fire = 1'b1;
      end else begin
        countdown <= countdown - 1;
      end
    end else if (cache_msg_out != NO_REQ) begin
      draw = {$random(seed)} % 4;
      if (draw == 0) begin
        fire = 1'b1;
      end else begin
        busy      <= 1'b1;
        countdown <= draw - 1;
      end
    end
    if (fire) begin
      busy      <= 1'b0;
      answering <= 1'b1;
      if (cache_msg_out == WB_REQ) begin
        lines[index]  <= cache_data_out;
        cache_msg_in  <= MEM_RESP;
        cache_data_in <= '0;
      end else begin
        // lines with address bit 4 set are held shared
        cache_msg_in  <= cache_address_out[4] ? MEM_RESP_S : MEM_RESP;
        cache_data_in <= lines[index];
      end
    end
  end

endmodule

// ==== test/lx_bus_interface_tb.sv ====
module lx_bus_interface_tb
  import lx_bus_pkg::*;
#(
  parameter int SEED = 49
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_ROWS = 7;
  localparam int MODEL_LINES = 8;
  localparam int WAIT_LIMIT = 20;
  localparam int STALL_CYCLES = 4;
  localparam int HOLD_CYCLES = 3;

  typedef struct packed {
    msg_t                  msg;
    logic [ADDR_WIDTH-1:0] address;
    beat_t                 beat_a;
    beat_t                 beat_b;
    logic                  ready;
  } row_t;

  logic                  clock;
  logic                  reset;
  logic                  req_ready;
  msg_t                  bus_msg_in;
  logic [ADDR_WIDTH-1:0] bus_address_in;
  beat_t                 bus_data_in;
  msg_t                  bus_msg_out;
  logic [ADDR_WIDTH-1:0] bus_address_out;
  beat_t                 bus_data_out;
  msg_t                  cache_msg_in;
  line_t                 cache_data_in;
  msg_t                  cache_msg_out;
  logic [ADDR_WIDTH-1:0] cache_address_out;
  line_t                 cache_data_out;

  row_t  rows [NUM_ROWS];
  line_t expected_lines [MODEL_LINES];
  int    error_count = 0;
  int    timeout_count = 0;
  logic  aborted = 1'b0;

  lx_bus_interface i_lx_bus_interface (
    .clock             (clock),
    .reset             (reset),
    .req_ready         (req_ready),
    .bus_msg_in        (bus_msg_in),
    .bus_address_in    (bus_address_in),
    .bus_data_in       (bus_data_in),
    .bus_msg_out       (bus_msg_out),
    .bus_address_out   (bus_address_out),
    .bus_data_out      (bus_data_out),
    .cache_msg_in      (cache_msg_in),
    .cache_data_in     (cache_data_in),
    .cache_msg_out     (cache_msg_out),
    .cache_address_out (cache_address_out),
    .cache_data_out    (cache_data_out)
  );

  cache_model #(.SEED(SEED)) i_cache_model (
    .clock             (clock),
    .reset             (reset),
    .cache_msg_out     (cache_msg_out),
    .cache_address_out (cache_address_out),
    .cache_data_out    (cache_data_out),
    .cache_msg_in      (cache_msg_in),
    .cache_data_in     (cache_data_in)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // cache contents before any write-back
  function automatic word_t expected_fill(input int index, input int word);
    return {8'h5a, 16'(index), 8'(word)};
  endfunction

  function automatic int line_index(input logic [ADDR_WIDTH-1:0] address);
    return int'(address[LINE_OFFSET_BITS+2:LINE_OFFSET_BITS]);
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] line_address(input logic [ADDR_WIDTH-1:0] address);
    logic [ADDR_WIDTH-1:0] mask;
    mask = (1 << LINE_OFFSET_BITS) - 1;
    return address & ~mask;
  endfunction

  function automatic msg_t expected_resp(input logic [ADDR_WIDTH-1:0] address);
    return address[4] ? MEM_RESP_S : MEM_RESP;
  endfunction

  task automatic check_msg(input msg_t actual, input msg_t expected, input string what);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s is %s, expected %s",
               $time, what, actual.name(), expected.name());
      error_count++;
    end
  endtask

  task automatic check_address(input logic [ADDR_WIDTH-1:0] actual,
                               input logic [ADDR_WIDTH-1:0] expected, input string what);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      error_count++;
    end
  endtask

  task automatic check_beat(input beat_t actual, input beat_t expected, input string what);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      error_count++;
    end
  endtask

  task automatic check_line(input line_t actual, input line_t expected, input string what);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      error_count++;
    end
  endtask

  task automatic wait_cache_request();
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (cache_msg_out == NO_REQ && cycles < WAIT_LIMIT) begin
      @(negedge clock);
      cycles++;
    end
    if (cache_msg_out == NO_REQ) begin
      $display("Timeout: the cache saw no request within %0d cycles", WAIT_LIMIT);
      timeout_count++;
      aborted = 1'b1;
    end
  endtask

  task automatic wait_bus_response();
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (bus_msg_out == NO_REQ && cycles < WAIT_LIMIT) begin
      @(negedge clock);
      cycles++;
    end
    if (bus_msg_out == NO_REQ) begin
      $display("Timeout: no response reached the bus within %0d cycles", WAIT_LIMIT);
      timeout_count++;
      aborted = 1'b1;
    end
  endtask

  task automatic wait_bus_clear();
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (bus_msg_out != NO_REQ && cycles < WAIT_LIMIT) begin
      @(negedge clock);
      cycles++;
    end
    if (bus_msg_out != NO_REQ) begin
      $display("Timeout: the bus response did not clear within %0d cycles", WAIT_LIMIT);
      timeout_count++;
      aborted = 1'b1;
    end
  endtask

  task automatic load_table();
    rows[0] = '{WB_REQ,    32'h0000_0104, 64'h1111_0001_1111_0000, 64'h1111_0003_1111_0002, 1'b1};
    rows[1] = '{R_REQ,     32'h0000_0106, 64'h0, 64'h0, 1'b1};
    rows[2] = '{RFO_BCAST, 32'h0000_0013, 64'h0, 64'h0, 1'b1};
    rows[3] = '{WB_REQ,    32'h0000_0218, 64'h2222_0001_2222_0000, 64'h2222_0003_2222_0002, 1'b0};
    rows[4] = '{R_REQ,     32'h0000_021a, 64'h0, 64'h0, 1'b0};
    rows[5] = '{RFO_BCAST, 32'h0000_0008, 64'h0, 64'h0, 1'b1};
    rows[6] = '{R_REQ,     32'h0000_0105, 64'h0, 64'h0, 1'b1};
  endtask

  // on return the next rising edge is the acceptance edge
  task automatic present_request(input row_t r);
    @(posedge clock);
    bus_msg_in     <= r.msg;
    bus_address_in <= r.address;
    req_ready      <= r.ready;
    if (!r.ready) begin
      repeat (STALL_CYCLES) begin
        @(negedge clock);
        check_msg(cache_msg_out, NO_REQ, "cache message while req_ready is low");
      end
      @(posedge clock);
      req_ready <= 1'b1;
    end
  endtask

  task automatic run_read(input row_t r);
    line_t expected;
    msg_t  resp;
    expected = expected_lines[line_index(r.address)];
    resp     = expected_resp(r.address);
    present_request(r);
    wait_cache_request();
    if (aborted) return;
    check_msg(cache_msg_out, r.msg, "cache request message");
    check_address(cache_address_out, line_address(r.address), "cache request address");
    wait_bus_response();
    if (aborted) return;
    check_msg(bus_msg_out, resp, "read response message");
    check_address(bus_address_out, r.address, "read response address");
    check_beat(bus_data_out, expected.beats[0], "read beat 0");
    check_msg(cache_msg_out, NO_REQ, "cache message after response");
    @(negedge clock);
    check_msg(bus_msg_out, resp, "read response message on beat 1");
    check_beat(bus_data_out, expected.beats[1], "read beat 1");
    @(negedge clock);
    check_msg(bus_msg_out, NO_REQ, "bus message after last beat");
    check_address(bus_address_out, '0, "bus address after last beat");
    check_beat(bus_data_out, '0, "bus data after last beat");
    // request is still held and nothing new may start
    repeat (HOLD_CYCLES) begin
      @(negedge clock);
      check_msg(cache_msg_out, NO_REQ, "cache message before the bus went idle");
    end
    @(posedge clock);
    bus_msg_in <= NO_REQ;
    repeat (2) @(posedge clock);
  endtask

  task automatic run_write_back(input row_t r);
    line_t written;
    written.beats[0] = r.beat_a;
    written.beats[1] = r.beat_b;
    present_request(r);
    // acceptance edge followed by one beat per cycle
    @(posedge clock);
    bus_data_in <= r.beat_a;
    @(posedge clock);
    bus_data_in <= r.beat_b;
    @(posedge clock);
    bus_data_in <= '0;
    wait_cache_request();
    if (aborted) return;
    check_msg(cache_msg_out, WB_REQ, "cache write-back message");
    check_address(cache_address_out, line_address(r.address), "cache write-back address");
    check_line(cache_data_out, written, "cache write-back line");
    wait_bus_response();
    if (aborted) return;
    check_msg(bus_msg_out, MEM_RESP, "write-back ack message");
    check_address(bus_address_out, r.address, "write-back ack address");
    repeat (HOLD_CYCLES) begin
      @(negedge clock);
      check_msg(bus_msg_out, MEM_RESP, "write-back ack while request held");
    end
    @(posedge clock);
    bus_msg_in <= NO_REQ;
    wait_bus_clear();
    if (aborted) return;
    expected_lines[line_index(r.address)] = written;
    repeat (2) @(posedge clock);
  endtask

  initial begin
    reset          <= 1'b1;
    req_ready      <= 1'b0;
    bus_msg_in     <= NO_REQ;
    bus_address_in <= '0;
    bus_data_in    <= '0;
    load_table();
    for (int i = 0; i < MODEL_LINES; i++) begin
      for (int w = 0; w < CACHE_WORDS; w++) begin
        expected_lines[i].words[w] = expected_fill(i, w);
      end
    end
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_msg(bus_msg_out, NO_REQ, "bus message after reset");
    check_msg(cache_msg_out, NO_REQ, "cache message after reset");
    check_address(bus_address_out, '0, "bus address after reset");
    check_address(cache_address_out, '0, "cache address after reset");
    check_beat(bus_data_out, '0, "bus data after reset");
    check_line(cache_data_out, '0, "cache data after reset");
    for (int r = 0; r < NUM_ROWS && !aborted; r++) begin
      if (rows[r].msg == WB_REQ) begin
        run_write_back(rows[r]);
      end else begin
        run_read(rows[r]);
      end
    end
    $display("Summary: %0d errors, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
